// ==== hw/obufPkg.sv ====
// Single clock domain only; source supplies complete frames with FCS, single-part FrameLink
package obufPkg;

  // ------------------------------
  // Data path types
  // ------------------------------
  typedef logic [63:0] flData_t;
  // Index of last valid byte in the EOF word
  typedef logic [2:0]  flRem_t;
  // Valid bytes in one word, 1 to 8
  typedef logic [3:0]  byteCnt_t;
  typedef logic [15:0] frameLen_t;
  // Lane 0 is the low byte
  typedef logic [63:0] xgmiiData_t;
  typedef logic [7:0]  xgmiiCtrl_t;
  typedef logic [31:0] mi32Addr_t;
  typedef logic [31:0] mi32Data_t;

  // ------------------------------
  // Buffer sizing
  // ------------------------------
  localparam int BUF_WORDS   = 512;
  localparam int BUF_AW      = $clog2(BUF_WORDS);
  localparam int FRAME_CNT_W = 10;
  typedef logic [BUF_AW-1:0] bufPtr_t;
  // One extra bit so a full FIFO is distinct from empty
  typedef logic [BUF_AW:0]   bufCnt_t;

  // ------------------------------
  // XGMII characters
  // ------------------------------
  localparam logic [7:0] XGMII_IDLE    = 8'h07;
  localparam logic [7:0] XGMII_START   = 8'hFB;
  localparam logic [7:0] XGMII_TERM    = 8'hFD;
  localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0] SFD_BYTE      = 8'hD5;

  // MI32 register map, byte offsets
  localparam mi32Addr_t REG_CTRL   = 32'h0;
  localparam mi32Addr_t REG_FRAMES = 32'h4;
  localparam mi32Addr_t REG_BYTES  = 32'h8;
  localparam mi32Addr_t REG_STATUS = 32'hC;

  // Encoder FSM
  typedef enum logic [2:0] {
    sIdle,
    sStart,
    sData,
    sTerm,
    sIfg
  } encState_t;

endpackage

// ==== hw/obufIfc.sv ====
// Buffer ports carry no clock; all users sit on XGMII_CLK
`timescale 1ns/1ps

// Decode to buffer write port
interface bufWrIfc import obufPkg::*; ();
  flData_t  data;
  byteCnt_t bytes;
  logic     last;
  logic     we;
  // Fewer than two free words
  logic     full;

  modport writer (output data, bytes, last, we, input full);
  modport buffer (input data, bytes, last, we, output full);
endinterface

// Buffer to encoder read port, first-word-fall-through
interface bufRdIfc import obufPkg::*; ();
  flData_t  data;
  byteCnt_t bytes;
  logic     last;
  logic     re;
  // At least one complete frame stored
  logic     frameAvail;

  modport reader (input data, bytes, last, frameAvail, output re);
  modport buffer (output data, bytes, last, frameAvail, input re);
endinterface

// ==== hw/flDecode.sv ====
// Single-part frames only; words outside a SOF..EOF span are dropped without notice
`timescale 1ns/1ps

module flDecode import obufPkg::*; (
  input  logic     XGMII_CLK,
  input  logic     arstN,
  // FrameLink receive side, active low controls
  input  flData_t  flData,
  input  flRem_t   flRem,
  input  logic     flSofN,
  input  logic     flEofN,
  input  logic     flSrcRdyN,
  output logic     flDstRdyN,
  // Buffer write port
  bufWrIfc.writer  wr
);

  // ------------------------------
  // Transfer qualification
  // ------------------------------
  logic accept;
  logic frameOpen;
  logic inFrame;

  // Word moves when both sides are ready
  assign accept  = !flSrcRdyN && !flDstRdyN;
  // SOF word opens a frame even when it is also the EOF word
  assign inFrame = frameOpen || !flSofN;

  // ------------------------------
  // Buffer write, no added latency
  // ------------------------------
  assign wr.we   = accept && inFrame;
  assign wr.data = flData;
  assign wr.last = !flEofN;

  always_comb begin
    // Full word unless this is the tail
    wr.bytes = byteCnt_t'(8);
    if (!flEofN) begin
      wr.bytes = byteCnt_t'(flRem) + 1'b1;
    end
  end

  // ------------------------------
  // Frame tracking and ready
  // ------------------------------
  always_ff @(posedge XGMII_CLK or negedge arstN) begin
    if (!arstN) begin
      frameOpen <= 1'b0;
      flDstRdyN <= 1'b0;
    end else begin
      // Registered full, buffer keeps one word of slack for this
      flDstRdyN <= wr.full;
      if (accept && inFrame) begin
        // EOF closes, otherwise stay open
        frameOpen <= flEofN;
      end
    end
  end

  // ------------------------------
  // Protocol checks
  // ------------------------------
  // A new SOF must not land inside an open frame
  assert property (@(posedge XGMII_CLK) disable iff (!arstN)
    (accept && frameOpen) |-> flSofN)
  else $error("FrameLink SOF while frame open");

endmodule

// ==== hw/frameBuffer.sv ====
// Depth BUF_WORDS; frames longer than the buffer would never be released
`timescale 1ns/1ps

module frameBuffer import obufPkg::*; (
  input  logic     XGMII_CLK,
  input  logic     arstN,
  bufWrIfc.buffer  wr,
  bufRdIfc.buffer  rd,
  output logic     bufEmpty
);

  // ------------------------------
  // Storage
  // ------------------------------
  flData_t  dataMem  [BUF_WORDS];
  byteCnt_t bytesMem [BUF_WORDS];
  logic     lastMem  [BUF_WORDS];

  bufPtr_t  wrPtr;
  bufPtr_t  rdPtr;
  bufCnt_t  count;
  logic [FRAME_CNT_W-1:0] frameCnt;

  logic push;
  logic pop;

  assign push = wr.we;
  assign pop  = rd.re;

  always_ff @(posedge XGMII_CLK) begin
    if (push) begin
      dataMem[wrPtr]  <= wr.data;
      bytesMem[wrPtr] <= wr.bytes;
      lastMem[wrPtr]  <= wr.last;
    end
  end

  // Head word always visible
  assign rd.data  = dataMem[rdPtr];
  assign rd.bytes = bytesMem[rdPtr];
  assign rd.last  = lastMem[rdPtr];

  // ------------------------------
  // Pointers and counts
  // ------------------------------
  always_ff @(posedge XGMII_CLK or negedge arstN) begin
    if (!arstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      frameCnt <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Stored frame count, last flag marks a frame boundary
      case ({push && wr.last, pop && rd.last})
        2'b10:   frameCnt <= frameCnt + 1'b1;
        2'b01:   frameCnt <= frameCnt - 1'b1;
        default: frameCnt <= frameCnt;
      endcase
    end
  end

  // Two-word margin covers the registered ready in decode
  assign wr.full       = count >= bufCnt_t'(BUF_WORDS - 1);
  assign rd.frameAvail = frameCnt != '0;
  assign bufEmpty      = count == '0;

  // ------------------------------
  // Checks
  // ------------------------------
  assert property (@(posedge XGMII_CLK) disable iff (!arstN)
    push |-> (count != bufCnt_t'(BUF_WORDS)))
  else $error("Write into full buffer");

  assert property (@(posedge XGMII_CLK) disable iff (!arstN)
    pop |-> !bufEmpty)
  else $error("Read from empty buffer");

endmodule

// ==== hw/xgmiiEncode.sv ====
// No FCS, padding or deficit idle count; one idle word minimum between frames
`timescale 1ns/1ps

module xgmiiEncode import obufPkg::*; (
  input  logic       XGMII_CLK,
  input  logic       arstN,
  input  logic       enable,
  bufRdIfc.reader    rd,
  output xgmiiData_t xgmiiTxd,
  output xgmiiCtrl_t xgmiiTxc,
  output logic       frameSent,
  output frameLen_t  frameBytes
);

  encState_t state;
  encState_t nextState;
  frameLen_t byteSum;

  // ------------------------------
  // FSM and output decode
  // ------------------------------
  always_comb begin
    nextState = state;
    rd.re     = 1'b0;
    // Idle word unless a state overrides it
    xgmiiTxd  = {8{XGMII_IDLE}};
    xgmiiTxc  = '1;
    case (state)
      sIdle: begin
        // Only whole frames are started
        if (enable && rd.frameAvail) begin
          nextState = sStart;
        end
      end
      sStart: begin
        // START in lane 0, SFD in lane 7
        xgmiiTxd  = {SFD_BYTE, {6{PREAMBLE_BYTE}}, XGMII_START};
        xgmiiTxc  = 8'h01;
        nextState = sData;
      end
      sData: begin
        rd.re    = 1'b1;
        xgmiiTxd = rd.data;
        xgmiiTxc = '0;
        if (rd.last) begin
          if (rd.bytes == byteCnt_t'(8)) begin
            // Terminate spills into next word
            nextState = sTerm;
          end else begin
            nextState = sIfg;
            for (int lane = 0; lane < 8; lane++) begin
              if (byteCnt_t'(lane) == rd.bytes) begin
                xgmiiTxd[lane*8 +: 8] = XGMII_TERM;
                xgmiiTxc[lane]        = 1'b1;
              end else if (byteCnt_t'(lane) > rd.bytes) begin
                xgmiiTxd[lane*8 +: 8] = XGMII_IDLE;
                xgmiiTxc[lane]        = 1'b1;
              end
            end
          end
        end
      end
      sTerm: begin
        xgmiiTxd  = {{7{XGMII_IDLE}}, XGMII_TERM};
        nextState = sIfg;
      end
      sIfg: begin
        // Mandatory all-idle word
        nextState = sIdle;
      end
      default: begin
        nextState = sIdle;
      end
    endcase
  end

  // ------------------------------
  // State and byte accounting
  // ------------------------------
  always_ff @(posedge XGMII_CLK or negedge arstN) begin
    if (!arstN) begin
      state     <= sIdle;
      byteSum   <= '0;
      frameSent <= 1'b0;
    end else begin
      state     <= nextState;
      frameSent <= 1'b0;
      if (state == sStart) begin
        byteSum <= '0;
      end else if (rd.re) begin
        byteSum <= byteSum + frameLen_t'(rd.bytes);
        if (rd.last) begin
          frameSent <= 1'b1;
        end
      end
    end
  end

  // Total valid alongside the pulse
  always_ff @(posedge XGMII_CLK) begin
    if (rd.re && rd.last) begin
      frameBytes <= byteSum + frameLen_t'(rd.bytes);
    end
  end

  // Reads stay inside a complete stored frame
  assert property (@(posedge XGMII_CLK) disable iff (!arstN)
    rd.re |-> rd.frameAvail)
  else $error("Encoder read with no frame available");

endmodule

// ==== hw/mi32Regs.sv ====
// Accesses always accepted, no address-ready; counters wrap at 32 bits
`timescale 1ns/1ps

module mi32Regs import obufPkg::*; (
  input  logic      XGMII_CLK,
  input  logic      arstN,
  input  mi32Addr_t mi32Addr,
  input  mi32Data_t mi32Dwr,
  input  logic      mi32Wr,
  input  logic      mi32Rd,
  input  logic      frameSent,
  input  frameLen_t frameBytes,
  input  logic      bufEmpty,
  output mi32Data_t mi32Drd,
  output logic      mi32Drdy,
  output logic      enable
);

  mi32Data_t sentFrames;
  mi32Data_t sentBytes;
  logic      ctrlWr;
  logic      cntClear;

  assign ctrlWr   = mi32Wr && (mi32Addr == REG_CTRL);
  // Bit 1 is a strobe, never stored
  assign cntClear = ctrlWr && mi32Dwr[1];

  // ------------------------------
  // Control and statistics
  // ------------------------------
  always_ff @(posedge XGMII_CLK or negedge arstN) begin
    if (!arstN) begin
      enable     <= 1'b0;
      sentFrames <= '0;
      sentBytes  <= '0;
      mi32Drdy   <= 1'b0;
    end else begin
      mi32Drdy <= mi32Rd;
      if (ctrlWr) begin
        enable <= mi32Dwr[0];
      end
      // Clear wins over a frame ending in the same cycle
      if (cntClear) begin
        sentFrames <= '0;
        sentBytes  <= '0;
      end else if (frameSent) begin
        sentFrames <= sentFrames + 1'b1;
        sentBytes  <= sentBytes + mi32Data_t'(frameBytes);
      end
    end
  end

  // ------------------------------
  // Read data, one cycle after strobe
  // ------------------------------
  always_ff @(posedge XGMII_CLK) begin
    if (mi32Rd) begin
      case (mi32Addr)
        REG_CTRL:   mi32Drd <= {31'b0, enable};
        REG_FRAMES: mi32Drd <= sentFrames;
        REG_BYTES:  mi32Drd <= sentBytes;
        REG_STATUS: mi32Drd <= {31'b0, bufEmpty};
        default:    mi32Drd <= '0;
      endcase
    end
  end

endmodule

// ==== hw/obufTop.sv ====
// One clock XGMII_CLK for FrameLink, MI32 and XGMII; no link-state input
`timescale 1ns/1ps

module obufTop import obufPkg::*; (
  input  logic       XGMII_CLK,
  input  logic       arstN,
  // FrameLink in
  input  flData_t    flData,
  input  flRem_t     flRem,
  input  logic       flSofN,
  input  logic       flEofN,
  input  logic       flSrcRdyN,
  output logic       flDstRdyN,
  // XGMII SDR out
  output xgmiiData_t xgmiiTxd,
  output xgmiiCtrl_t xgmiiTxc,
  // MI32
  input  mi32Addr_t  mi32Addr,
  input  mi32Data_t  mi32Dwr,
  input  logic       mi32Wr,
  input  logic       mi32Rd,
  output mi32Data_t  mi32Drd,
  output logic       mi32Drdy
);

  bufWrIfc wrBus ();
  bufRdIfc rdBus ();

  logic      enable;
  logic      frameSent;
  frameLen_t frameBytes;
  logic      bufEmpty;

  // Decode, store, encode
  flDecode flDecode_i (.XGMII_CLK, .arstN, .flData, .flRem, .flSofN, .flEofN,
    .flSrcRdyN, .flDstRdyN, .wr(wrBus));

  frameBuffer frameBuffer_i (.XGMII_CLK, .arstN, .wr(wrBus), .rd(rdBus), .bufEmpty);

  xgmiiEncode xgmiiEncode_i (.XGMII_CLK, .arstN, .enable, .rd(rdBus), .xgmiiTxd,
    .xgmiiTxc, .frameSent, .frameBytes);

  // Register block beside the data path
  mi32Regs mi32Regs_i (.XGMII_CLK, .arstN, .mi32Addr, .mi32Dwr, .mi32Wr, .mi32Rd,
    .frameSent, .frameBytes, .bufEmpty, .mi32Drd, .mi32Drdy, .enable);

endmodule

// ==== sim/obufTb.sv ====
// Single clock; XGMII sampled on the falling edge; frames must fit the buffer; seed fixed
`timescale 1ns/1ps

module obufTb import obufPkg::*; ();

  localparam int WORD_TIMEOUT  = 4000;
  localparam int FRAME_TIMEOUT = 6000;
  localparam int MI32_TIMEOUT  = 16;

  logic       XGMII_CLK;
  logic       arstN;
  flData_t    flData;
  flRem_t     flRem;
  logic       flSofN;
  logic       flEofN;
  logic       flSrcRdyN;
  logic       flDstRdyN;
  xgmiiData_t xgmiiTxd;
  xgmiiCtrl_t xgmiiTxc;
  mi32Addr_t  mi32Addr;
  mi32Data_t  mi32Dwr;
  logic       mi32Wr;
  logic       mi32Rd;
  mi32Data_t  mi32Drd;
  logic       mi32Drdy;

  int         errors;
  int         startCount;
  int         collectedFrames;
  int         collectedBytes;
  logic       backPressure;
  logic       inFrame;
  logic       needIdle;
  // Expected stream, lengths and bytes kept apart
  int         expLenQ[$];
  logic [7:0] expByteQ[$];
  logic [7:0] rxQ[$];

  obufTop obufTop_i (.XGMII_CLK, .arstN, .flData, .flRem, .flSofN, .flEofN, .flSrcRdyN,
    .flDstRdyN, .xgmiiTxd, .xgmiiTxc, .mi32Addr, .mi32Dwr, .mi32Wr, .mi32Rd, .mi32Drd,
    .mi32Drdy);

  initial begin
    XGMII_CLK = 1'b0;
    forever #4 XGMII_CLK = ~XGMII_CLK;
  end

  // ------------------------------
  // Drivers
  // ------------------------------
  // Step to 1 ns past the next rising edge
  task automatic tick();
    @(posedge XGMII_CLK);
    #1;
  endtask

  task automatic sendFrame(input int len);
    logic [7:0] bytes[$];
    flData_t    word;
    int         words;
    int         w;
    int         b;
    int         cnt;
    for (b = 0; b < len; b++) begin
      bytes.push_back(8'($urandom));
      expByteQ.push_back(bytes[b]);
    end
    expLenQ.push_back(len);
    words = (len + 7) / 8;
    for (w = 0; w < words; w++) begin
      word = '0;
      for (b = 0; b < 8; b++) begin
        if (w * 8 + b < len) begin
          word[b*8 +: 8] = bytes[w*8 + b];
        end
      end
      flData    = word;
      flRem     = (w == words - 1) ? flRem_t'((len - 1) % 8) : 3'd7;
      flSofN    = (w != 0);
      flEofN    = (w != words - 1);
      flSrcRdyN = 1'b0;
      // Ready is stable between edges, so it is checked here
      cnt = 0;
      while (flDstRdyN && cnt < WORD_TIMEOUT) begin
        tick();
        cnt++;
      end
      if (flDstRdyN) begin
        $display("Timeout while waiting for flDstRdyN, word %0d of a %0d byte frame", w, len);
        errors++;
      end
      tick();
    end
    flSrcRdyN = 1'b1;
    flSofN    = 1'b1;
    flEofN    = 1'b1;
  endtask

  task automatic mi32Write(input mi32Addr_t addr, input mi32Data_t data);
    mi32Addr = addr;
    mi32Dwr  = data;
    mi32Wr   = 1'b1;
    tick();
    mi32Wr   = 1'b0;
  endtask

  task automatic mi32Read(input mi32Addr_t addr, output mi32Data_t data);
    int cnt;
    mi32Addr = addr;
    mi32Rd   = 1'b1;
    tick();
    mi32Rd   = 1'b0;
    cnt = 0;
    while (!mi32Drdy && cnt < MI32_TIMEOUT) begin
      tick();
      cnt++;
    end
    data = mi32Drd;
    if (!mi32Drdy) begin
      $display("Timeout while waiting for mi32Drdy, address %h", addr);
      errors++;
      data = '0;
    end
  endtask

  task automatic expectReg(input mi32Addr_t addr, input mi32Data_t exp, input string name);
    mi32Data_t got;
    mi32Read(addr, got);
    if (got !== exp) begin
      $display("FAILED at %0t: %s read %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic waitFrames(input int n);
    int cnt;
    cnt = 0;
    while (collectedFrames < n && cnt < FRAME_TIMEOUT) begin
      tick();
      cnt++;
    end
    if (collectedFrames < n) begin
      $display("Timeout: %0d frames seen on XGMII, %0d expected", collectedFrames, n);
      errors++;
    end
  endtask

  // ------------------------------
  // XGMII collector
  // ------------------------------
  task automatic checkFrame(input int termLane);
    int len;
    int i;
    if (expLenQ.size() == 0) begin
      $display("FAILED at %0t: frame of %0d bytes with none expected", $time, rxQ.size());
      errors++;
      return;
    end
    len = expLenQ.pop_front();
    if (rxQ.size() != len) begin
      $display("FAILED at %0t: frame length %0d, expected %0d", $time, rxQ.size(), len);
      errors++;
    end
    // Terminate lane follows directly from the length
    if (termLane != len % 8) begin
      $display("FAILED at %0t: terminate in lane %0d, expected %0d", $time, termLane, len % 8);
      errors++;
    end
    for (i = 0; i < len; i++) begin
      if (i < rxQ.size() && rxQ[i] !== expByteQ[0]) begin
        $display("FAILED at %0t: byte %0d is %h, expected %h", $time, i, rxQ[i], expByteQ[0]);
        errors++;
      end
      void'(expByteQ.pop_front());
    end
    collectedFrames++;
    collectedBytes += len;
  endtask

  always @(negedge XGMII_CLK) begin : collect
    int termLane;
    if (arstN) begin
      if (!inFrame) begin
        if (xgmiiTxc[0] && xgmiiTxd[7:0] == XGMII_START) begin
          if (needIdle) begin
            $display("FAILED at %0t: start with no idle word after last frame", $time);
            errors++;
          end
          if (xgmiiTxc != 8'h01 || xgmiiTxd[63:8] != {SFD_BYTE, {6{PREAMBLE_BYTE}}}) begin
            $display("FAILED at %0t: bad start word %h/%h", $time, xgmiiTxc, xgmiiTxd);
            errors++;
          end
          inFrame = 1'b1;
          startCount++;
          rxQ.delete();
        end else if (xgmiiTxc != 8'hFF || xgmiiTxd != {8{XGMII_IDLE}}) begin
          $display("FAILED at %0t: non-idle word %h/%h between frames", $time, xgmiiTxc,
            xgmiiTxd);
          errors++;
        end else begin
          needIdle = 1'b0;
        end
      end else begin
        termLane = -1;
        for (int lane = 0; lane < 8; lane++) begin
          if (termLane >= 0) begin
            // Tail after terminate must be idle
            if (!xgmiiTxc[lane] || xgmiiTxd[lane*8 +: 8] != XGMII_IDLE) begin
              $display("FAILED at %0t: lane %0d after terminate not idle", $time, lane);
              errors++;
            end
          end else if (!xgmiiTxc[lane]) begin
            rxQ.push_back(xgmiiTxd[lane*8 +: 8]);
          end else if (xgmiiTxd[lane*8 +: 8] == XGMII_TERM) begin
            termLane = lane;
          end else begin
            $display("FAILED at %0t: control %h in lane %0d inside frame", $time,
              xgmiiTxd[lane*8 +: 8], lane);
            errors++;
          end
        end
        if (termLane >= 0) begin
          checkFrame(termLane);
          inFrame  = 1'b0;
          needIdle = 1'b1;
        end
      end
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    int        sent;
    int        pollCnt;
    mi32Data_t got;
    void'($urandom(24042));
    errors = 0;
    startCount = 0;
    collectedFrames = 0;
    collectedBytes = 0;
    backPressure = 1'b0;
    inFrame = 1'b0;
    needIdle = 1'b0;
    arstN = 1'b0;
    flData = '0;
    flRem = '0;
    flSofN = 1'b1;
    flEofN = 1'b1;
    flSrcRdyN = 1'b1;
    mi32Addr = '0;
    mi32Dwr = '0;
    mi32Wr = 1'b0;
    mi32Rd = 1'b0;
    repeat (3) @(posedge XGMII_CLK);
    #1;
    arstN = 1'b1;

    // Reset values, idle line checked by the collector
    if (flDstRdyN !== 1'b0) begin
      $display("FAILED at %0t: flDstRdyN high after reset", $time);
      errors++;
    end
    expectReg(REG_FRAMES, 0, "REG_FRAMES");
    expectReg(REG_BYTES, 0, "REG_BYTES");
    expectReg(REG_CTRL, 0, "REG_CTRL");
    expectReg(REG_STATUS, 1, "REG_STATUS");

    // Disabled output holds a stored frame back
    sendFrame(16 + $urandom % 48);
    repeat (40) tick();
    if (startCount != 0) begin
      $display("FAILED at %0t: XGMII start seen while disabled", $time);
      errors++;
    end
    expectReg(REG_STATUS, 0, "REG_STATUS");
    mi32Write(REG_CTRL, 1);
    waitFrames(1);

    // Every remainder value
    for (int len = 8; len <= 15; len++) begin
      sendFrame(len);
    end
    waitFrames(9);

    // Fill until back-pressure, then release
    mi32Write(REG_CTRL, 0);
    sent = 9;
    fork
      begin
        while (!backPressure && sent < 80) begin
          sendFrame(64 + $urandom % 192);
          sent++;
        end
      end
      begin : releaseOutput
        int cnt;
        cnt = 0;
        while (!flDstRdyN && cnt < WORD_TIMEOUT) begin
          tick();
          cnt++;
        end
        if (!flDstRdyN) begin
          $display("Timeout: flDstRdyN never went high with output disabled");
          errors++;
        end
        backPressure = 1'b1;
        mi32Write(REG_CTRL, 1);
      end
    join
    waitFrames(sent);

    // Statistics settle a few cycles after the last terminate word
    pollCnt = 0;
    mi32Read(REG_FRAMES, got);
    while (got != mi32Data_t'(collectedFrames) && pollCnt < MI32_TIMEOUT) begin
      mi32Read(REG_FRAMES, got);
      pollCnt++;
    end

    // Statistics and clear
    expectReg(REG_FRAMES, collectedFrames, "REG_FRAMES");
    expectReg(REG_BYTES, collectedBytes, "REG_BYTES");
    mi32Write(REG_CTRL, 2);
    expectReg(REG_FRAMES, 0, "REG_FRAMES after clear");
    expectReg(REG_BYTES, 0, "REG_BYTES after clear");
    expectReg(REG_CTRL, 0, "REG_CTRL after clear");
    if (expLenQ.size() != 0) begin
      $display("FAILED at %0t: %0d frames never sent", $time, expLenQ.size());
      errors++;
    end

    $display("Frames collected: %0d, bytes: %0d, errors: %0d", collectedFrames,
      collectedBytes, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Run time limit
  initial begin
    #2000000;
    $display("Watchdog expired before the test sequence finished");
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== flist.f ====
hw/obufPkg.sv
hw/obufIfc.sv
hw/flDecode.sv
hw/frameBuffer.sv
hw/xgmiiEncode.sv
hw/mi32Regs.sv
hw/obufTop.sv
sim/obufTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the output buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary --timing --assert -Wno-fatal --top-module obufTb \
  -f flist.f -o obufSim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/obufSim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "FAIL: see errors above" "$SIM_LOG"; then
  exit 1
fi
exit 0
